// ==== design/modmul_pkg.sv ====
package modmul_pkg;

    // ------------------------------------------------------------------
    // widths and depths
    // ------------------------------------------------------------------
    localparam int word_w          = 32;
    localparam int step_cnt_w      = $clog2(word_w + 1);
    localparam int job_depth       = 4;
    localparam int res_depth       = 4;
    localparam int res_credit_init = 2;

    typedef logic [word_w-1:0] word_t;

    typedef enum logic [1:0] {
        mod_p31,
        mod_p30,
        mod_p16
    } mod_sel_t;

    // ------------------------------------------------------------------
    // modulus and rho = 2^64 mod m per mod_sel_t
    // ------------------------------------------------------------------
    localparam word_t mod_table [3] = '{
        32'd2147483647,
        32'd1000000007,
        32'd65521
    };

    localparam word_t rho_table [3] = '{
        32'd4,
        32'd582344008,
        32'd50625
    };

    typedef struct packed {
        mod_sel_t mod_sel;
        word_t    x;
        word_t    y;
    } job_t;

    typedef struct packed {
        mod_sel_t mod_sel;
        word_t    value;
    } result_t;

endpackage

// ==== design/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     not_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;

    assign not_empty = (count != '0);
    assign not_full  = (count < cnt_w'(depth));
    // head is visible without a pop
    assign pop_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    // upstream credits must keep these from ever firing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> not_full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> not_empty);

endmodule

// ==== design/mont_mul.sv ====
`timescale 1ns/1ps

module mont_mul import modmul_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mm_start,
    input  word_t mm_a,
    input  word_t mm_b,
    input  word_t mm_m,
    output word_t mm_p,
    output logic  mm_done
);

    logic                  busy;
    logic [step_cnt_w-1:0] step;
    word_t                 a_q;
    word_t                 b_q;
    word_t                 m_q;
    // partial sum stays below 2m and needs one bit above the word
    logic [word_w:0]       s_q;
    logic [word_w+1:0]     sum_ab;
    logic [word_w+1:0]     sum_m;
    logic [word_w:0]       s_diff;

    // ------------------------------------------------------------------
    // one radix-2 step per cycle
    // ------------------------------------------------------------------
    always_comb begin
        sum_ab = {1'b0, s_q} + (a_q[0] ? {2'b00, b_q} : '0);
        // make the sum even before halving
        sum_m  = sum_ab + (sum_ab[0] ? {2'b00, m_q} : '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= '0;
        end else if (mm_start) begin
            busy <= 1'b1;
            step <= '0;
        end else if (mm_done) begin
            busy <= 1'b0;
        end else if (busy) begin
            step <= step + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mm_start) begin
            a_q <= mm_a;
            b_q <= mm_b;
            m_q <= mm_m;
            s_q <= '0;
        end else if (busy && !mm_done) begin
            a_q <= a_q >> 1;
            s_q <= sum_m[word_w+1:1];
        end
    end

    // final conditional subtract
    assign mm_done = busy && (step == step_cnt_w'(word_w));
    assign s_diff  = s_q - {1'b0, m_q};
    assign mm_p    = (s_q >= {1'b0, m_q}) ? s_diff[word_w-1:0] : s_q[word_w-1:0];

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) mm_start |-> !busy);

endmodule

// ==== design/modmul_sequencer.sv ====
`timescale 1ns/1ps

module modmul_sequencer import modmul_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  job_t    job_head,
    input  logic    job_avail,
    input  logic    mm_done,
    input  word_t   mm_p,
    input  logic    res_space,
    output logic    job_pop,
    output logic    mm_start,
    output word_t   mm_a,
    output word_t   mm_b,
    output word_t   mm_m,
    output logic    res_push,
    output result_t res_data
);

    typedef enum logic [2:0] {
        st_idle,
        st_x_rho,
        st_y_rho,
        st_mul,
        st_from_mont,
        st_done
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_nxt;
    job_t       job_q;
    // r0 holds x in Montgomery form and later the product
    word_t      r0_q;
    // r1 holds y in Montgomery form and later the final value
    word_t      r1_q;
    word_t      rho;
    logic       start_q;

    // ------------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (job_avail) state_nxt = st_x_rho;
            end
            st_x_rho: begin
                if (mm_done) state_nxt = st_y_rho;
            end
            st_y_rho: begin
                if (mm_done) state_nxt = st_mul;
            end
            st_mul: begin
                if (mm_done) state_nxt = st_from_mont;
            end
            st_from_mont: begin
                if (mm_done) state_nxt = st_done;
            end
            st_done: begin
                // hold the result until the buffer has room
                if (res_space) state_nxt = st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            start_q <= 1'b0;
        end else begin
            state   <= state_nxt;
            start_q <= (state_nxt != state) &&
                       (state_nxt inside {st_x_rho, st_y_rho, st_mul, st_from_mont});
        end
    end

    always_ff @(posedge clk) begin
        if (job_pop) begin
            job_q <= job_head;
        end
        if (mm_done) begin
            case (state)
                st_x_rho, st_mul:       r0_q <= mm_p;
                st_y_rho, st_from_mont: r1_q <= mm_p;
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // operand select
    // ------------------------------------------------------------------
    assign rho  = rho_table[job_q.mod_sel];
    assign mm_m = mod_table[job_q.mod_sel];

    always_comb begin
        case (state)
            st_y_rho: begin
                mm_a = job_q.y;
                mm_b = rho;
            end
            st_mul: begin
                mm_a = r0_q;
                mm_b = r1_q;
            end
            st_from_mont: begin
                mm_a = r0_q;
                mm_b = word_t'(1);
            end
            default: begin
                mm_a = job_q.x;
                mm_b = rho;
            end
        endcase
    end

    assign job_pop  = (state == st_idle) && job_avail;
    assign mm_start = start_q;
    assign res_push = (state == st_done) && res_space;
    assign res_data = '{mod_sel: job_q.mod_sel, value: r1_q};

    a_known_mod: assert property (@(posedge clk) disable iff (!rst_n)
        job_pop |-> job_head.mod_sel inside {mod_p31, mod_p30, mod_p16});

endmodule

// ==== design/result_sender.sv ====
`timescale 1ns/1ps

module result_sender import modmul_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    res_push,
    input  result_t res_data,
    input  logic    result_credit,
    output logic    res_space,
    output logic    result_valid,
    output result_t result
);

    localparam int credit_w = $clog2(res_credit_init + 1);

    logic [credit_w-1:0] credit_cnt;
    logic                buf_avail;
    logic                send;
    result_t             buf_head;

    credit_fifo #(
        .payload_t (result_t),
        .depth     (res_depth)
    ) res_buf_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (res_push),
        .push_data (res_data),
        .pop       (send),
        .pop_data  (buf_head),
        .not_empty (buf_avail),
        .not_full  (res_space)
    );

    assign send = buf_avail && (credit_cnt != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt   <= credit_w'(res_credit_init);
            result_valid <= 1'b0;
        end else begin
            credit_cnt   <= credit_cnt - credit_w'(send) + credit_w'(result_credit);
            result_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            result <= buf_head;
        end
    end

    // consumer returns only what it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        result_credit |-> credit_cnt < credit_w'(res_credit_init));

endmodule

// ==== design/modmul_top.sv ====
`timescale 1ns/1ps

module modmul_top import modmul_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    job_valid,
    input  job_t    job,
    input  logic    result_credit,
    output logic    job_credit,
    output logic    result_valid,
    output result_t result
);

    job_t    job_head;
    logic    job_avail;
    logic    job_pop;
    logic    mm_start;
    word_t   mm_a;
    word_t   mm_b;
    word_t   mm_m;
    word_t   mm_p;
    logic    mm_done;
    logic    res_push;
    result_t res_data;
    logic    res_space;

    // each pop frees a queue slot that goes upstream as a credit
    assign job_credit = job_pop;

    credit_fifo #(
        .payload_t (job_t),
        .depth     (job_depth)
    ) job_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (job_valid),
        .push_data (job),
        .pop       (job_pop),
        .pop_data  (job_head),
        .not_empty (job_avail),
        .not_full  ()
    );

    modmul_sequencer sequencer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .job_head  (job_head),
        .job_avail (job_avail),
        .mm_done   (mm_done),
        .mm_p      (mm_p),
        .res_space (res_space),
        .job_pop   (job_pop),
        .mm_start  (mm_start),
        .mm_a      (mm_a),
        .mm_b      (mm_b),
        .mm_m      (mm_m),
        .res_push  (res_push),
        .res_data  (res_data)
    );

    mont_mul mont_mul_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mm_start (mm_start),
        .mm_a     (mm_a),
        .mm_b     (mm_b),
        .mm_m     (mm_m),
        .mm_p     (mm_p),
        .mm_done  (mm_done)
    );

    result_sender result_sender_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .res_push      (res_push),
        .res_data      (res_data),
        .result_credit (result_credit),
        .res_space     (res_space),
        .result_valid  (result_valid),
        .result        (result)
    );

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 4;
    localparam int reset_cycles = 3;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // release just after an edge so the first active edge is clean
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== bench/modmul_tb.sv ====
`timescale 1ns/1ps

module modmul_tb import modmul_pkg::*; ();

    localparam int num_jobs       = 65;
    localparam int timeout_cycles = 140 * num_jobs + 500;
    // pop to push for a single job
    localparam int job_cycles     = 4 * (word_w + 2) + 1;

    typedef enum int {
        ret_now,
        ret_hold,
        ret_random
    } credit_mode_t;

    logic    clk;
    logic    rst_n;
    logic    job_valid;
    job_t    job;
    logic    result_credit;
    logic    job_credit;
    logic    result_valid;
    result_t result;

    result_t      exp_q [$];
    result_t      expected;
    int           job_credits    = job_depth;
    int           jobs_in_flight = 0;
    int           credit_pulses  = 0;
    int           res_credits    = res_credit_init;
    int           credits_owed   = 0;
    int           release_budget = 0;
    int           results_seen   = 0;
    int           cycle_cnt      = 0;
    credit_mode_t credit_mode    = ret_now;

    clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    modmul_top modmul_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .job_valid     (job_valid),
        .job           (job),
        .result_credit (result_credit),
        .job_credit    (job_credit),
        .result_valid  (result_valid),
        .result        (result)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (act_v !== exp_v) begin
            stop_on_error($sformatf("FAIL at %0d ns: %s expected 0x%0h, got 0x%0h",
                                    $time, name, exp_v, act_v));
        end
    endtask

    // plain 64-bit product reduced by the table modulus
    function automatic word_t mulmod_ref(input mod_sel_t sel, input word_t x, input word_t y);
        logic [63:0] prod;
        prod = 64'(x) * 64'(y);
        return word_t'(prod % 64'(mod_table[sel]));
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_job(input mod_sel_t sel, input word_t x, input word_t y);
        while (job_credits == 0) begin
            next_cycle();
        end
        job_valid = 1'b1;
        job       = '{mod_sel: sel, x: x, y: y};
        job_credits--;
        jobs_in_flight++;
        exp_q.push_back(result_t'{mod_sel: sel, value: mulmod_ref(sel, x, y)});
        next_cycle();
        job_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || credits_owed != 0) begin
            next_cycle();
        end
    endtask

    // ------------------------------------------------------------------
    // monitors, consumer credits, timeout
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n && job_credit) begin
            if (jobs_in_flight == 0) begin
                stop_on_error("job_credit pulsed with no job outstanding");
            end else begin
                jobs_in_flight--;
                job_credits++;
                credit_pulses++;
            end
        end
        if (rst_n && result_valid) begin
            if (res_credits == 0) begin
                stop_on_error("result_valid seen while the consumer had no credit out");
            end else if (exp_q.size() == 0) begin
                stop_on_error("result_valid seen with no result expected");
            end else begin
                expected = exp_q.pop_front();
                check_value("result.mod_sel", 64'(expected.mod_sel), 64'(result.mod_sel));
                check_value("result.value", 64'(expected.value), 64'(result.value));
                res_credits--;
                credits_owed++;
                results_seen++;
            end
        end
    end

    initial begin
        logic give;
        result_credit = 1'b0;
        forever begin
            next_cycle();
            result_credit = 1'b0;
            case (credit_mode)
                ret_now:    give = 1'b1;
                ret_random: give = ($urandom_range(3, 0) == 0);
                default:    give = (release_budget > 0);
            endcase
            if (credits_owed > 0 && give) begin
                result_credit = 1'b1;
                credits_owed--;
                res_credits++;
                if (credit_mode == ret_hold) begin
                    release_budget--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            stop_on_error($sformatf("timeout: run still busy after %0d cycles", cycle_cnt));
        end
    end

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic quiet_after_reset();
        repeat (20) begin
            next_cycle();
            check_value("job_credit", 64'(0), 64'(job_credit));
            check_value("result_valid", 64'(0), 64'(result_valid));
        end
    endtask

    task automatic one_job_per_modulus();
        credit_mode = ret_now;
        send_job(mod_p31, 32'd123456789, 32'd987654321);
        send_job(mod_p30, 32'd999999999, 32'd123456789);
        send_job(mod_p16, 32'd65000, 32'd12345);
        wait_drain();
    endtask

    task automatic edge_operands();
        word_t m;
        for (int s = 0; s < 3; s++) begin
            m = mod_table[s];
            send_job(mod_sel_t'(s), 32'd0, m - 1);
            send_job(mod_sel_t'(s), 32'd1, m - 2);
            send_job(mod_sel_t'(s), m - 1, m - 1);
            send_job(mod_sel_t'(s), m / 2 + 1, 32'd1);
        end
        wait_drain();
    endtask

    task automatic back_to_back_jobs();
        int pulses0;
        pulses0     = credit_pulses;
        credit_mode = ret_now;
        check_value("job credits held", 64'(job_depth), 64'(job_credits));
        for (int i = 0; i < 4; i++) begin
            send_job(mod_p30, word_t'(700000000 + 12345 * i), word_t'(999999000 - i));
        end
        wait_drain();
        check_value("job_credit pulses", 64'(4), 64'(credit_pulses - pulses0));
    endtask

    task automatic output_back_pressure();
        int pulses0;
        int seen0;
        int n;
        credit_mode    = ret_hold;
        release_budget = 0;
        pulses0        = credit_pulses;
        seen0          = results_seen;
        for (int i = 0; i < 6; i++) begin
            send_job(mod_sel_t'(i % 3), word_t'(1000 * i + 7), word_t'(54321 - i));
        end
        while (credit_pulses - pulses0 < 6) begin
            next_cycle();
        end
        // last job still has a full pass to run
        repeat (job_cycles + 4) begin
            next_cycle();
        end
        check_value("results before credit return", 64'(res_credit_init),
                    64'(results_seen - seen0));
        while (results_seen - seen0 < 6) begin
            n              = results_seen;
            release_budget = 1;
            while (results_seen == n) begin
                next_cycle();
            end
        end
        credit_mode = ret_now;
        wait_drain();
    endtask

    task automatic random_jobs();
        mod_sel_t sel;
        word_t    m;
        credit_mode = ret_random;
        for (int i = 0; i < 40; i++) begin
            sel = mod_sel_t'($urandom_range(2, 0));
            m   = mod_table[sel];
            send_job(sel, $urandom % m, $urandom % m);
        end
        wait_drain();
    endtask

    initial begin
        void'($urandom(87518));
        job_valid = 1'b0;
        job       = '0;
        wait (rst_n === 1'b1);
        next_cycle();
        quiet_after_reset();
        one_job_per_modulus();
        edge_operands();
        back_to_back_jobs();
        output_back_pressure();
        random_jobs();
        credit_mode = ret_now;
        wait_drain();
        if (exp_q.size() != 0 || job_credits != job_depth || res_credits != res_credit_init) begin
            stop_on_error("run ended with results or credits still outstanding");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== modmul_top.f ====
design/modmul_pkg.sv
design/credit_fifo.sv
design/mont_mul.sv
design/modmul_sequencer.sv
design/result_sender.sv
design/modmul_top.sv
bench/clk_gen.sv
bench/modmul_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= modmul_tb
FILELIST  ?= modmul_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the simulation printed the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
